// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module mem_subsystem_tb -f src.f -o sim_tb \
    > sim.log 2>&1 \
    && ./obj_dir/sim_tb >> sim.log 2>&1 \
    || echo "Something failed" >> sim.log
grep -q "Something failed" sim.log && { echo "FAIL, see sim.log"; exit 1; } || echo "PASS"

// ==== source/load_align.sv ====
`default_nettype none

module load_align import lsu_pkg::*; (
    input  logic [DATA_WIDTH-1:0]   rdata_i,
    input  logic [FUNCT3_WIDTH-1:0] funct3_i,
    input  logic [1:0]              addr_lo_i,
    output logic [DATA_WIDTH-1:0]   data_o
);

    logic [DATA_WIDTH-1:0] shifted;

    // Move the addressed lane down to bit 0
    assign shifted = rdata_i >> {addr_lo_i, 3'b000};

    always_comb begin
        case (funct3_i)
            F3_B: begin
                data_o = {{(DATA_WIDTH-8){shifted[7]}}, shifted[7:0]};
            end
            F3_H: begin
                data_o = {{(DATA_WIDTH-16){shifted[15]}}, shifted[15:0]};
            end
            F3_BU: begin
                data_o = {{(DATA_WIDTH-8){1'b0}}, shifted[7:0]};
            end
            F3_HU: begin
                data_o = {{(DATA_WIDTH-16){1'b0}}, shifted[15:0]};
            end
            // Word loads and anything unknown pass straight through
            default: begin
                data_o = rdata_i;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    // Word and register index widths
    localparam int DATA_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int STRB_WIDTH     = DATA_WIDTH / 8;

    // Instruction field widths
    localparam int OPCODE_WIDTH = 7;
    localparam int FUNCT3_WIDTH = 3;

    // RISC-V opcodes handled by this stage
    localparam logic [OPCODE_WIDTH-1:0] OPCODE_LOAD  = 7'b000_0011;
    localparam logic [OPCODE_WIDTH-1:0] OPCODE_STORE = 7'b010_0011;

    // funct3 access kinds, shared by loads and stores
    localparam logic [FUNCT3_WIDTH-1:0] F3_B  = 3'b000;
    localparam logic [FUNCT3_WIDTH-1:0] F3_H  = 3'b001;
    localparam logic [FUNCT3_WIDTH-1:0] F3_W  = 3'b010;
    localparam logic [FUNCT3_WIDTH-1:0] F3_BU = 3'b100;
    localparam logic [FUNCT3_WIDTH-1:0] F3_HU = 3'b101;

    // Data memory geometry, word index taken from address bits 9:2
    localparam int MEM_DEPTH      = 256;
    localparam int MEM_ADDR_WIDTH = 8;

    // Reset value of the pc and instruction registers
    localparam logic [DATA_WIDTH-1:0] RESET_PC = 32'h8000_0000;

    // AXI4-Lite response codes
    localparam int                   RESP_WIDTH = 2;
    localparam logic [RESP_WIDTH-1:0] RESP_OKAY = 2'b00;

    // Stage controller states
    localparam int                    STATE_WIDTH = 2;
    localparam logic [STATE_WIDTH-1:0] ST_IDLE   = 2'd0;
    localparam logic [STATE_WIDTH-1:0] ST_ACCESS = 2'd1;
    localparam logic [STATE_WIDTH-1:0] ST_DONE   = 2'd2;

endpackage

`default_nettype wire

// ==== source/mem_stage.sv ====
`default_nettype none

module mem_stage import lsu_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    // From execute
    input  logic                      start_i,
    input  logic [DATA_WIDTH-1:0]     pc_i,
    input  logic [DATA_WIDTH-1:0]     inst_i,
    input  logic [DATA_WIDTH-1:0]     result_i,
    input  logic [DATA_WIDTH-1:0]     addr_i,
    input  logic [DATA_WIDTH-1:0]     rs2_data_i,
    input  logic [REG_ADDR_WIDTH-1:0] rd_addr_i,
    // To writeback
    output logic [DATA_WIDTH-1:0]     pc_o,
    output logic [DATA_WIDTH-1:0]     inst_o,
    output logic [DATA_WIDTH-1:0]     result_o,
    output logic [DATA_WIDTH-1:0]     load_data_o,
    output logic [REG_ADDR_WIDTH-1:0] rd_addr_o,
    output logic                      done_o,
    // AXI4-Lite master
    output logic                      awvalid_o,
    output logic [DATA_WIDTH-1:0]     awaddr_o,
    input  logic                      awready_i,
    output logic                      wvalid_o,
    output logic [DATA_WIDTH-1:0]     wdata_o,
    output logic [STRB_WIDTH-1:0]     wstrb_o,
    input  logic                      wready_i,
    input  logic                      bvalid_i,
    input  logic [RESP_WIDTH-1:0]     bresp_i,
    output logic                      arvalid_o,
    output logic [DATA_WIDTH-1:0]     araddr_o,
    input  logic                      arready_i,
    input  logic                      rvalid_i,
    input  logic [DATA_WIDTH-1:0]     rdata_i,
    input  logic [RESP_WIDTH-1:0]     rresp_i
);

    logic [STATE_WIDTH-1:0]    state_q;
    logic                      aw_done_q;
    logic                      w_done_q;
    logic                      ar_done_q;
    logic [DATA_WIDTH-1:0]     pc_q;
    logic [DATA_WIDTH-1:0]     inst_q;
    logic [DATA_WIDTH-1:0]     result_q;
    logic [DATA_WIDTH-1:0]     addr_q;
    logic [DATA_WIDTH-1:0]     rs2_q;
    logic [REG_ADDR_WIDTH-1:0] rd_q;
    logic [DATA_WIDTH-1:0]     load_data_q;
    logic [DATA_WIDTH-1:0]     aligned_data;
    logic [OPCODE_WIDTH-1:0]   opcode;
    logic [FUNCT3_WIDTH-1:0]   funct3;
    logic                      is_load;
    logic                      is_store;
    logic                      in_is_mem;

    // Decode from the captured instruction
    assign opcode   = inst_q[6:0];
    assign funct3   = inst_q[14:12];
    assign is_load  = (opcode == OPCODE_LOAD);
    assign is_store = (opcode == OPCODE_STORE);

    // Only the branch out of IDLE looks at the incoming opcode
    assign in_is_mem = (inst_i[6:0] == OPCODE_LOAD) || (inst_i[6:0] == OPCODE_STORE);

    load_align u_load_align (
        .rdata_i   (rdata_i),
        .funct3_i  (funct3),
        .addr_lo_i (addr_q[1:0]),
        .data_o    (aligned_data)
    );

    store_mask_gen u_store_mask_gen (
        .funct3_i    (funct3),
        .addr_lo_i   (addr_q[1:0]),
        .wdata_raw_i (rs2_q),
        .wstrb_o     (wstrb_o),
        .wdata_o     (wdata_o)
    );

    // Requests stay up until their channel has been accepted
    assign awvalid_o = (state_q == ST_ACCESS) && is_store && !aw_done_q;
    assign wvalid_o  = (state_q == ST_ACCESS) && is_store && !w_done_q;
    assign arvalid_o = (state_q == ST_ACCESS) && is_load && !ar_done_q;
    assign awaddr_o  = addr_q;
    assign araddr_o  = addr_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= ST_IDLE;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
            ar_done_q <= 1'b0;
            pc_q      <= RESET_PC;
            inst_q    <= RESET_PC;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        pc_q    <= pc_i;
                        inst_q  <= inst_i;
                        state_q <= in_is_mem ? ST_ACCESS : ST_DONE;
                    end
                end
                ST_ACCESS: begin
                    if (awvalid_o && awready_i) begin
                        aw_done_q <= 1'b1;
                    end
                    if (wvalid_o && wready_i) begin
                        w_done_q <= 1'b1;
                    end
                    if (arvalid_o && arready_i) begin
                        ar_done_q <= 1'b1;
                    end
                    // Response ends the access
                    if (bvalid_i || rvalid_i) begin
                        aw_done_q <= 1'b0;
                        w_done_q  <= 1'b0;
                        ar_done_q <= 1'b0;
                        state_q   <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    state_q <= ST_IDLE;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Payload side of the capture
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && start_i) begin
            result_q <= result_i;
            addr_q   <= addr_i;
            rs2_q    <= rs2_data_i;
            rd_q     <= rd_addr_i;
        end
        if (state_q == ST_ACCESS && rvalid_i) begin
            load_data_q <= aligned_data;
        end
    end

    assign pc_o        = pc_q;
    assign inst_o      = inst_q;
    assign result_o    = result_q;
    assign rd_addr_o   = rd_q;
    assign load_data_o = load_data_q;
    assign done_o      = (state_q == ST_DONE);

    a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
        start_i |-> state_q == ST_IDLE);

    a_aw_w_paired: assert property (@(posedge clk) disable iff (rst)
        awvalid_o == wvalid_o);

    // Responses only while an access is open, and never an error
    a_resp_in_access: assert property (@(posedge clk) disable iff (rst)
        (bvalid_i || rvalid_i) |-> state_q == ST_ACCESS);

    a_resp_okay: assert property (@(posedge clk) disable iff (rst)
        (!bvalid_i || bresp_i == RESP_OKAY) && (!rvalid_i || rresp_i == RESP_OKAY));

    a_natural_align: assert property (@(posedge clk) disable iff (rst)
        (state_q == ST_ACCESS && (is_load || is_store)) |->
            (((funct3 == F3_H || funct3 == F3_HU) -> addr_q[0] == 1'b0) &&
             ((funct3 == F3_W) -> addr_q[1:0] == 2'b00)));

endmodule

`default_nettype wire

// ==== source/mem_subsystem.sv ====
`default_nettype none

module mem_subsystem import lsu_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start_i,
    input  logic [DATA_WIDTH-1:0]     pc_i,
    input  logic [DATA_WIDTH-1:0]     inst_i,
    input  logic [DATA_WIDTH-1:0]     result_i,
    input  logic [DATA_WIDTH-1:0]     addr_i,
    input  logic [DATA_WIDTH-1:0]     rs2_data_i,
    input  logic [REG_ADDR_WIDTH-1:0] rd_addr_i,
    output logic [DATA_WIDTH-1:0]     pc_o,
    output logic [DATA_WIDTH-1:0]     inst_o,
    output logic [DATA_WIDTH-1:0]     result_o,
    output logic [DATA_WIDTH-1:0]     load_data_o,
    output logic [REG_ADDR_WIDTH-1:0] rd_addr_o,
    output logic                      done_o
);

    // AXI4-Lite between stage and memory
    logic                  awvalid;
    logic [DATA_WIDTH-1:0] awaddr;
    logic                  awready;
    logic                  wvalid;
    logic [DATA_WIDTH-1:0] wdata;
    logic [STRB_WIDTH-1:0] wstrb;
    logic                  wready;
    logic                  bvalid;
    logic [RESP_WIDTH-1:0] bresp;
    logic                  arvalid;
    logic [DATA_WIDTH-1:0] araddr;
    logic                  arready;
    logic                  rvalid;
    logic [DATA_WIDTH-1:0] rdata;
    logic [RESP_WIDTH-1:0] rresp;

    mem_stage u_mem_stage (
        .clk         (clk),
        .rst         (rst),
        .start_i     (start_i),
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .result_i    (result_i),
        .addr_i      (addr_i),
        .rs2_data_i  (rs2_data_i),
        .rd_addr_i   (rd_addr_i),
        .pc_o        (pc_o),
        .inst_o      (inst_o),
        .result_o    (result_o),
        .load_data_o (load_data_o),
        .rd_addr_o   (rd_addr_o),
        .done_o      (done_o),
        .awvalid_o   (awvalid),
        .awaddr_o    (awaddr),
        .awready_i   (awready),
        .wvalid_o    (wvalid),
        .wdata_o     (wdata),
        .wstrb_o     (wstrb),
        .wready_i    (wready),
        .bvalid_i    (bvalid),
        .bresp_i     (bresp),
        .arvalid_o   (arvalid),
        .araddr_o    (araddr),
        .arready_i   (arready),
        .rvalid_i    (rvalid),
        .rdata_i     (rdata),
        .rresp_i     (rresp)
    );

    sram_axi_lite u_sram (
        .clk       (clk),
        .rst       (rst),
        .awvalid_i (awvalid),
        .awaddr_i  (awaddr),
        .awready_o (awready),
        .wvalid_i  (wvalid),
        .wdata_i   (wdata),
        .wstrb_i   (wstrb),
        .wready_o  (wready),
        .bvalid_o  (bvalid),
        .bresp_o   (bresp),
        .arvalid_i (arvalid),
        .araddr_i  (araddr),
        .arready_o (arready),
        .rvalid_o  (rvalid),
        .rdata_o   (rdata),
        .rresp_o   (rresp)
    );

endmodule

`default_nettype wire

// ==== source/sram_axi_lite.sv ====
`default_nettype none

module sram_axi_lite import lsu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    // Write address and data
    input  logic                  awvalid_i,
    input  logic [DATA_WIDTH-1:0] awaddr_i,
    output logic                  awready_o,
    input  logic                  wvalid_i,
    input  logic [DATA_WIDTH-1:0] wdata_i,
    input  logic [STRB_WIDTH-1:0] wstrb_i,
    output logic                  wready_o,
    // Write response
    output logic                  bvalid_o,
    output logic [RESP_WIDTH-1:0] bresp_o,
    // Read address and data
    input  logic                  arvalid_i,
    input  logic [DATA_WIDTH-1:0] araddr_i,
    output logic                  arready_o,
    output logic                  rvalid_o,
    output logic [DATA_WIDTH-1:0] rdata_o,
    output logic [RESP_WIDTH-1:0] rresp_o
);

    logic [DATA_WIDTH-1:0]     mem_q [MEM_DEPTH];
    logic [DATA_WIDTH-1:0]     rdata_q;
    logic                      bvalid_q;
    logic                      rvalid_q;
    logic                      idle;
    logic                      wr_fire;
    logic                      rd_fire;
    logic [MEM_ADDR_WIDTH-1:0] wr_idx;
    logic [MEM_ADDR_WIDTH-1:0] rd_idx;

    // One transaction at a time, nothing accepted while a response is out
    assign idle    = !bvalid_q && !rvalid_q;
    assign wr_fire = idle && awvalid_i && wvalid_i;
    // Write wins when both show up together
    assign rd_fire = idle && arvalid_i && !wr_fire;

    assign awready_o = wr_fire;
    assign wready_o  = wr_fire;
    assign arready_o = rd_fire;

    // Word index, upper address bits are ignored
    assign wr_idx = awaddr_i[MEM_ADDR_WIDTH+1:2];
    assign rd_idx = araddr_i[MEM_ADDR_WIDTH+1:2];

    // Responses last one cycle since the master is always ready
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            bvalid_q <= wr_fire;
            rvalid_q <= rd_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int i = 0; i < STRB_WIDTH; i++) begin
                if (wstrb_i[i]) begin
                    mem_q[wr_idx][8*i +: 8] <= wdata_i[8*i +: 8];
                end
            end
        end
        if (rd_fire) begin
            rdata_q <= mem_q[rd_idx];
        end
    end

    assign bvalid_o = bvalid_q;
    assign bresp_o  = RESP_OKAY;
    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;
    assign rresp_o  = RESP_OKAY;

    a_one_resp: assert property (@(posedge clk) disable iff (rst)
        !(bvalid_q && rvalid_q));

endmodule

`default_nettype wire

// ==== source/store_mask_gen.sv ====
`default_nettype none

module store_mask_gen import lsu_pkg::*; (
    input  logic [FUNCT3_WIDTH-1:0] funct3_i,
    input  logic [1:0]              addr_lo_i,
    input  logic [DATA_WIDTH-1:0]   wdata_raw_i,
    output logic [STRB_WIDTH-1:0]   wstrb_o,
    output logic [DATA_WIDTH-1:0]   wdata_o
);

    always_comb begin
        case (funct3_i)
            F3_B: begin
                wstrb_o = 4'b0001 << addr_lo_i;
                // Same byte on every lane, strobe picks the one written
                wdata_o = {4{wdata_raw_i[7:0]}};
            end
            F3_H: begin
                wstrb_o = 4'b0011 << addr_lo_i;
                wdata_o = {2{wdata_raw_i[15:0]}};
            end
            F3_W: begin
                wstrb_o = 4'b1111;
                wdata_o = wdata_raw_i;
            end
            default: begin
                wstrb_o = '0;
                wdata_o = wdata_raw_i;
            end
        endcase
    end

    // A legal store kind always touches at least one byte
    always_comb begin
        if (funct3_i == F3_B || funct3_i == F3_H || funct3_i == F3_W) begin
            assert (wstrb_o != '0)
                else $error("store_mask_gen: empty strobe for funct3 %b", funct3_i);
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
source/lsu_pkg.sv
source/load_align.sv
source/store_mask_gen.sv
source/mem_stage.sv
source/sram_axi_lite.sv
source/mem_subsystem.sv
verif/mem_subsystem_tb.sv

// ==== verif/mem_subsystem_tb.sv ====
`default_nettype none

module mem_subsystem_tb import lsu_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DONE_TIMEOUT = 20;
    localparam logic [OPCODE_WIDTH-1:0] OPCODE_OP     = 7'b011_0011;
    localparam logic [OPCODE_WIDTH-1:0] OPCODE_OP_IMM = 7'b001_0011;

    typedef struct packed {
        logic [OPCODE_WIDTH-1:0]   opcode;
        logic [FUNCT3_WIDTH-1:0]   funct3;
        logic [DATA_WIDTH-1:0]     addr;
        logic [DATA_WIDTH-1:0]     data;
        logic [DATA_WIDTH-1:0]     result;
        logic [REG_ADDR_WIDTH-1:0] rd;
    } entry_t;

    logic                      clk;
    logic                      rst;
    logic                      start_i;
    logic [DATA_WIDTH-1:0]     pc_i;
    logic [DATA_WIDTH-1:0]     inst_i;
    logic [DATA_WIDTH-1:0]     result_i;
    logic [DATA_WIDTH-1:0]     addr_i;
    logic [DATA_WIDTH-1:0]     rs2_data_i;
    logic [REG_ADDR_WIDTH-1:0] rd_addr_i;
    logic [DATA_WIDTH-1:0]     pc_o;
    logic [DATA_WIDTH-1:0]     inst_o;
    logic [DATA_WIDTH-1:0]     result_o;
    logic [DATA_WIDTH-1:0]     load_data_o;
    logic [REG_ADDR_WIDTH-1:0] rd_addr_o;
    logic                      done_o;

    entry_t                table_q[$];
    logic [DATA_WIDTH-1:0] model_mem [MEM_DEPTH];
    logic [31:0]           lfsr_state;
    int                    mismatch_count;
    int                    timeout_count;

    mem_subsystem u_dut (
        .clk         (clk),
        .rst         (rst),
        .start_i     (start_i),
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .result_i    (result_i),
        .addr_i      (addr_i),
        .rs2_data_i  (rs2_data_i),
        .rd_addr_i   (rd_addr_i),
        .pc_o        (pc_o),
        .inst_o      (inst_o),
        .result_o    (result_o),
        .load_data_o (load_data_o),
        .rd_addr_o   (rd_addr_o),
        .done_o      (done_o)
    );

    always #2 clk = ~clk;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic random_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Reference memory, byte lanes picked by the low address bits
    task automatic model_store(input logic [FUNCT3_WIDTH-1:0] funct3,
                               input logic [DATA_WIDTH-1:0] addr,
                               input logic [DATA_WIDTH-1:0] data);
        logic [MEM_ADDR_WIDTH-1:0] idx;
        int                        lane;
        idx = addr[MEM_ADDR_WIDTH+1:2];
        lane = int'(addr[1:0]);
        case (funct3)
            F3_B: begin
                model_mem[idx][8*lane +: 8] = data[7:0];
            end
            F3_H: begin
                model_mem[idx][8*lane +: 16] = data[15:0];
            end
            default: begin
                model_mem[idx] = data;
            end
        endcase
    endtask

    function automatic logic [DATA_WIDTH-1:0] model_load(input logic [FUNCT3_WIDTH-1:0] funct3,
                                                         input logic [DATA_WIDTH-1:0] addr);
        logic [DATA_WIDTH-1:0] word;
        logic [7:0]            b;
        logic [15:0]           h;
        int                    lane;
        word = model_mem[addr[MEM_ADDR_WIDTH+1:2]];
        lane = int'(addr[1:0]);
        b = word[8*lane +: 8];
        h = word[16*(lane/2) +: 16];
        case (funct3)
            F3_B:    return {{24{b[7]}}, b};
            F3_BU:   return {24'h0, b};
            F3_H:    return {{16{h[15]}}, h};
            F3_HU:   return {16'h0, h};
            default: return word;
        endcase
    endfunction

    task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] expected,
                              input logic [DATA_WIDTH-1:0] actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_reg(input string name, input logic [REG_ADDR_WIDTH-1:0] expected,
                             input logic [REG_ADDR_WIDTH-1:0] actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_latency(input int expected, input int actual);
        if (actual != expected) begin
            mismatch_count++;
            $display("Error at %0t ns: done latency expected %0d, got %0d",
                     $time, expected, actual);
        end
    endtask

    task automatic add_entry(input logic [OPCODE_WIDTH-1:0] opcode,
                             input logic [FUNCT3_WIDTH-1:0] funct3,
                             input logic [DATA_WIDTH-1:0] addr,
                             input logic [DATA_WIDTH-1:0] data,
                             input logic [DATA_WIDTH-1:0] result,
                             input logic [REG_ADDR_WIDTH-1:0] rd);
        entry_t e;
        e.opcode = opcode;
        e.funct3 = funct3;
        e.addr   = addr;
        e.data   = data;
        e.result = result;
        e.rd     = rd;
        table_q.push_back(e);
    endtask

    task automatic build_table();
        // Word store and load back
        add_entry(OPCODE_STORE, F3_W, 32'h0000_0100, 32'h1234_5678, 32'h0000_0a01, 5'd1);
        add_entry(OPCODE_LOAD,  F3_W, 32'h0000_0100, 32'h0000_0000, 32'h0000_0a02, 5'd2);
        // Byte stores into each lane of a known word
        add_entry(OPCODE_STORE, F3_W, 32'h0000_0104, 32'ha5a5_a5a5, 32'h0000_0b01, 5'd3);
        add_entry(OPCODE_STORE, F3_B, 32'h0000_0104, 32'hffff_ff11, 32'h0000_0b02, 5'd4);
        add_entry(OPCODE_STORE, F3_B, 32'h0000_0105, 32'h0000_0022, 32'h0000_0b03, 5'd5);
        add_entry(OPCODE_LOAD,  F3_W, 32'h0000_0104, 32'h0000_0000, 32'h0000_0b04, 5'd6);
        add_entry(OPCODE_STORE, F3_B, 32'h0000_0106, 32'h1234_5633, 32'h0000_0b05, 5'd7);
        add_entry(OPCODE_STORE, F3_B, 32'h0000_0107, 32'hdead_be44, 32'h0000_0b06, 5'd8);
        add_entry(OPCODE_LOAD,  F3_W, 32'h0000_0104, 32'h0000_0000, 32'h0000_0b07, 5'd9);
        // Halfword stores into both lanes
        add_entry(OPCODE_STORE, F3_W, 32'h0000_0108, 32'h0f0f_0f0f, 32'h0000_0c01, 5'd10);
        add_entry(OPCODE_STORE, F3_H, 32'h0000_0108, 32'hffff_beef, 32'h0000_0c02, 5'd11);
        add_entry(OPCODE_LOAD,  F3_W, 32'h0000_0108, 32'h0000_0000, 32'h0000_0c03, 5'd12);
        add_entry(OPCODE_STORE, F3_H, 32'h0000_010a, 32'h1234_cafe, 32'h0000_0c04, 5'd13);
        add_entry(OPCODE_LOAD,  F3_W, 32'h0000_0108, 32'h0000_0000, 32'h0000_0c05, 5'd14);
        // Bytes 01 ff 7f 80 from lane 0 up
        add_entry(OPCODE_STORE, F3_W, 32'h0000_010c, 32'h807f_ff01, 32'h0000_0d01, 5'd15);
        add_entry(OPCODE_LOAD,  F3_B, 32'h0000_010c, 32'h0000_0000, 32'h0000_0d02, 5'd16);
        add_entry(OPCODE_LOAD,  F3_B, 32'h0000_010d, 32'h0000_0000, 32'h0000_0d03, 5'd17);
        add_entry(OPCODE_LOAD,  F3_B, 32'h0000_010e, 32'h0000_0000, 32'h0000_0d04, 5'd18);
        add_entry(OPCODE_LOAD,  F3_B, 32'h0000_010f, 32'h0000_0000, 32'h0000_0d05, 5'd19);
        add_entry(OPCODE_LOAD, F3_BU, 32'h0000_010c, 32'h0000_0000, 32'h0000_0d06, 5'd20);
        add_entry(OPCODE_LOAD, F3_BU, 32'h0000_010d, 32'h0000_0000, 32'h0000_0d07, 5'd21);
        add_entry(OPCODE_LOAD, F3_BU, 32'h0000_010e, 32'h0000_0000, 32'h0000_0d08, 5'd22);
        add_entry(OPCODE_LOAD, F3_BU, 32'h0000_010f, 32'h0000_0000, 32'h0000_0d09, 5'd23);
        // Halfwords 7ffe and 8001
        add_entry(OPCODE_STORE, F3_W, 32'h0000_0110, 32'h8001_7ffe, 32'h0000_0e01, 5'd24);
        add_entry(OPCODE_LOAD,  F3_H, 32'h0000_0110, 32'h0000_0000, 32'h0000_0e02, 5'd25);
        add_entry(OPCODE_LOAD,  F3_H, 32'h0000_0112, 32'h0000_0000, 32'h0000_0e03, 5'd26);
        add_entry(OPCODE_LOAD, F3_HU, 32'h0000_0110, 32'h0000_0000, 32'h0000_0e04, 5'd27);
        add_entry(OPCODE_LOAD, F3_HU, 32'h0000_0112, 32'h0000_0000, 32'h0000_0e05, 5'd28);
        // Non-memory ops leave load_data_o alone
        add_entry(OPCODE_OP,     F3_B, 32'h0000_0120, 32'h5555_5555, 32'hcafe_0001, 5'd29);
        add_entry(OPCODE_OP_IMM, F3_W, 32'h0000_0124, 32'haaaa_aaaa, 32'hcafe_0002, 5'd30);
        // Address bits above the word index alias
        add_entry(OPCODE_STORE, F3_W, 32'h0000_0514, 32'h0bad_f00d, 32'h0000_0f01, 5'd31);
        add_entry(OPCODE_LOAD,  F3_W, 32'h0000_0114, 32'h0000_0000, 32'h0000_0f02, 5'd0);
    endtask

    initial begin
        entry_t                e;
        logic [31:0]           filler;
        logic [DATA_WIDTH-1:0] exp_load;
        logic [DATA_WIDTH-1:0] exp_pc;
        logic [DATA_WIDTH-1:0] exp_inst;
        logic                  have_load;
        logic                  is_mem;
        int                    cycles;
        int                    expected_cycles;

        clk            = 1'b0;
        rst            = 1'b1;
        start_i        = 1'b0;
        pc_i           = '0;
        inst_i         = '0;
        result_i       = '0;
        addr_i         = '0;
        rs2_data_i     = '0;
        rd_addr_i      = '0;
        lfsr_state     = 32'hb587_8a73;
        mismatch_count = 0;
        timeout_count  = 0;
        have_load      = 1'b0;
        exp_load       = '0;
        build_table();

        repeat (3) @(negedge clk);
        rst = 1'b0;

        // State right after reset, before any start
        check_bit("done_o", 1'b0, done_o);
        check_word("pc_o", RESET_PC, pc_o);
        check_word("inst_o", RESET_PC, inst_o);

        for (int i = 0; i < table_q.size(); i++) begin
            e = table_q[i];
            random_bits(22, filler);
            inst_i = {filler[21:5], e.funct3, filler[4:0], e.opcode};
            random_bits(32, filler);
            pc_i       = filler;
            addr_i     = e.addr;
            rs2_data_i = e.data;
            result_i   = e.result;
            rd_addr_i  = e.rd;
            start_i    = 1'b1;
            exp_pc     = pc_i;
            exp_inst   = inst_i;

            is_mem = (e.opcode == OPCODE_LOAD) || (e.opcode == OPCODE_STORE);
            expected_cycles = is_mem ? 3 : 1;
            if (e.opcode == OPCODE_STORE) begin
                model_store(e.funct3, e.addr, e.data);
            end
            if (e.opcode == OPCODE_LOAD) begin
                exp_load  = model_load(e.funct3, e.addr);
                have_load = 1'b1;
            end

            cycles = 0;
            while (done_o !== 1'b1 && cycles < DONE_TIMEOUT) begin
                @(negedge clk);
                start_i = 1'b0;
                cycles++;
            end

            if (done_o !== 1'b1) begin
                timeout_count++;
                $display("Timeout at %0t ns: done never came for entry %0d", $time, i);
                break;
            end

            check_latency(expected_cycles, cycles);
            check_word("pc_o", exp_pc, pc_o);
            check_word("inst_o", exp_inst, inst_o);
            check_word("result_o", e.result, result_o);
            check_reg("rd_addr_o", e.rd, rd_addr_o);
            if (have_load) begin
                check_word("load_data_o", exp_load, load_data_o);
            end

            // done_o is a single-cycle pulse
            @(negedge clk);
            check_bit("done_o", 1'b0, done_o);
        end

        $display("Report: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
